/* verilog/core_pkg.sv */
// shared sizes, opcodes and packet structs for the out-of-order back end and its testbench
package core_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////////////////////

    // reorder buffer depth and tag width
    localparam int rob_sz       = 8;
    localparam int rob_tag_bits = 3;

    // datapath and register file
    localparam int xlen     = 32;
    localparam int num_regs = 32;
    localparam int reg_bits = 5;

    // multiply pipe depth, also its issue to data bus latency
    localparam int mul_latency = 3;

    ////////////////////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_xor,
        op_and,
        op_mul,
        op_store,
        op_nop
    } opcode_e;

    // per entry status inside the reorder buffer
    typedef enum logic [1:0] {
        rob_empty,
        rob_busy,
        rob_ready
    } rob_state_e;

    ////////////////////////////////////////////////////////////////////////////
    // packets
    ////////////////////////////////////////////////////////////////////////////

    // instruction as it arrives on the input port
    typedef struct packed {
        opcode_e               opcode;
        logic [reg_bits-1:0]   dest_reg;
        logic [xlen-1:0]       operand_a;
        logic [xlen-1:0]       operand_b;
    } instr_t;

    // dispatch to execution
    typedef struct packed {
        logic                    valid;
        logic [rob_tag_bits-1:0] tag;
        opcode_e                 opcode;
        logic [xlen-1:0]         operand_a;
        logic [xlen-1:0]         operand_b;
    } issue_packet_t;

    // allocation request, dispatch to reorder buffer
    typedef struct packed {
        logic                valid;
        opcode_e             opcode;
        logic [reg_bits-1:0] dest_reg;
    } dispatch_rob_packet_t;

    // allocation status back to dispatch
    typedef struct packed {
        logic [rob_tag_bits-1:0] tail_tag;
        logic                    full;
    } rob_dispatch_packet_t;

    // common data bus, one result per cycle
    typedef struct packed {
        logic                    valid;
        logic [rob_tag_bits-1:0] tag;
        logic [xlen-1:0]         value;
    } cdb_packet_t;

    // head of the reorder buffer as seen by retire
    typedef struct packed {
        logic                valid;
        logic                reg_valid;
        logic                mem_valid;
        logic [reg_bits-1:0] dest_reg;
        logic [xlen-1:0]     value;
    } retire_packet_t;

    // store port payload
    typedef struct packed {
        logic [xlen-1:0] address;
    } store_req_t;

endpackage

/* verilog/dispatch_stage.sv */
// dispatch stage taking instructions over the four-phase input port and issuing them with a tag
`timescale 1ns/100ps

module dispatch_stage (
    input  logic                           clock,
    input  logic                           reset,
    // instruction port
    input  logic                           in_req,
    input  core_pkg::instr_t               in_data,
    output logic                           in_ack,
    // reorder buffer allocation
    output core_pkg::dispatch_rob_packet_t rob_alloc,
    input  core_pkg::rob_dispatch_packet_t rob_status,
    // to execution
    output core_pkg::issue_packet_t        issue
);

    // handshake states
    typedef enum logic [1:0] {
        idle,
        ack_high,
        wait_drop
    } disp_state_e;

    disp_state_e state;
    logic        take;

    // accept only from idle and only with room in the buffer
    assign take = (state == idle) && in_req && !rob_status.full;

    ////////////////////////////////////////////////////////////////////////////
    // handshake
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (take) begin
                        state <= ack_high;
                    end
                end
                // first ack cycle, req may already be gone
                ack_high: begin
                    state <= in_req ? wait_drop : idle;
                end
                wait_drop: begin
                    if (!in_req) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // ack stays up until req has been seen low
    assign in_ack = (state != idle);

    ////////////////////////////////////////////////////////////////////////////
    // allocation and issue, single cycle pulses
    ////////////////////////////////////////////////////////////////////////////

    assign rob_alloc.valid    = take;
    assign rob_alloc.opcode   = in_data.opcode;
    assign rob_alloc.dest_reg = in_data.dest_reg;

    // tag is the tail the buffer offers this cycle
    assign issue.valid     = take;
    assign issue.tag       = rob_status.tail_tag;
    assign issue.opcode    = in_data.opcode;
    assign issue.operand_a = in_data.operand_a;
    assign issue.operand_b = in_data.operand_b;

endmodule

/* verilog/reorder_buffer.sv */
// reorder buffer holding in-flight results until they retire in program order from the head
`timescale 1ns/100ps

module reorder_buffer (
    input  logic                           clock,
    input  logic                           reset,
    // dispatch side
    input  core_pkg::dispatch_rob_packet_t dispatch_in,
    output core_pkg::rob_dispatch_packet_t dispatch_out,
    // completions
    input  core_pkg::cdb_packet_t          cdb_in,
    // retire side
    input  logic                           retire_entry,
    output core_pkg::retire_packet_t       retire_out
);

    // entry storage
    core_pkg::rob_state_e          entry_state  [core_pkg::rob_sz];
    core_pkg::opcode_e             entry_opcode [core_pkg::rob_sz];
    logic [core_pkg::reg_bits-1:0] entry_dest   [core_pkg::rob_sz];
    logic [core_pkg::xlen-1:0]     entry_value  [core_pkg::rob_sz];

    // pointers with an extra wrap bit on top
    logic [core_pkg::rob_tag_bits:0]   head;
    logic [core_pkg::rob_tag_bits:0]   tail;
    logic [core_pkg::rob_tag_bits-1:0] head_idx;
    logic [core_pkg::rob_tag_bits-1:0] tail_idx;

    logic full;
    logic alloc;
    logic head_ready;
    logic free_head;
    core_pkg::opcode_e head_op;

    assign head_idx = head[core_pkg::rob_tag_bits-1:0];
    assign tail_idx = tail[core_pkg::rob_tag_bits-1:0];

    // same slot, different lap
    assign full = (head_idx == tail_idx) &&
                  (head[core_pkg::rob_tag_bits] != tail[core_pkg::rob_tag_bits]);

    assign alloc      = dispatch_in.valid && !full;
    assign head_ready = (entry_state[head_idx] == core_pkg::rob_ready);
    assign free_head  = retire_entry && head_ready;
    assign head_op    = entry_opcode[head_idx];

    assign dispatch_out.tail_tag = tail_idx;
    assign dispatch_out.full     = full;

    ////////////////////////////////////////////////////////////////////////////
    // opcode classes
    ////////////////////////////////////////////////////////////////////////////

    // everything except store and nop writes a register
    function automatic logic writes_reg(input core_pkg::opcode_e op);
        return (op != core_pkg::op_store) && (op != core_pkg::op_nop);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // head presented to retire
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        retire_out.valid     = head_ready;
        // register 0 writes are dropped here
        retire_out.reg_valid = head_ready && writes_reg(head_op) &&
                               (entry_dest[head_idx] != '0);
        retire_out.mem_valid = head_ready && (head_op == core_pkg::op_store);
        retire_out.dest_reg  = entry_dest[head_idx];
        retire_out.value     = entry_value[head_idx];
    end

    ////////////////////////////////////////////////////////////////////////////
    // entry status and pointers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < core_pkg::rob_sz; i++) begin
                entry_state[i] <= core_pkg::rob_empty;
            end
            head <= '0;
            tail <= '0;
        end else begin
            // new entry at the tail
            if (alloc) begin
                entry_state[tail_idx] <= core_pkg::rob_busy;
                tail <= tail + 1'b1;
            end
            // result arrived, entry ready from next cycle
            if (cdb_in.valid) begin
                entry_state[cdb_in.tag] <= core_pkg::rob_ready;
            end
            // oldest entry leaves
            if (free_head) begin
                entry_state[head_idx] <= core_pkg::rob_empty;
                head <= head + 1'b1;
            end
        end
    end

    // payload fields, only meaningful while the entry is in use
    always_ff @(posedge clock) begin
        if (alloc) begin
            entry_opcode[tail_idx] <= dispatch_in.opcode;
            entry_dest[tail_idx]   <= dispatch_in.dest_reg;
        end
        if (cdb_in.valid) begin
            entry_value[cdb_in.tag] <= cdb_in.value;
        end
    end

endmodule

/* verilog/exec_unit.sv */
// execution unit with a single cycle ALU, a pipelined multiplier and common data bus arbitration
`timescale 1ns/100ps

module exec_unit (
    input  logic                    clock,
    input  logic                    reset,
    input  core_pkg::issue_packet_t issue,
    output core_pkg::cdb_packet_t   cdb_out
);

    core_pkg::cdb_packet_t alu_q;
    core_pkg::cdb_packet_t skid_q;
    core_pkg::cdb_packet_t mul_out;
    core_pkg::cdb_packet_t mul_pipe [core_pkg::mul_latency];

    logic [core_pkg::xlen-1:0] alu_result;
    logic [core_pkg::xlen-1:0] product;
    logic                      is_mul;

    assign is_mul = (issue.opcode == core_pkg::op_mul);

    ////////////////////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (issue.opcode)
            core_pkg::op_add:   alu_result = issue.operand_a + issue.operand_b;
            core_pkg::op_sub:   alu_result = issue.operand_a - issue.operand_b;
            core_pkg::op_xor:   alu_result = issue.operand_a ^ issue.operand_b;
            core_pkg::op_and:   alu_result = issue.operand_a & issue.operand_b;
            // store result is its address
            core_pkg::op_store: alu_result = issue.operand_a + issue.operand_b;
            default:            alu_result = '0;
        endcase
    end

    // only the low word is kept
    assign product = issue.operand_a * issue.operand_b;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            alu_q  <= '0;
            skid_q <= '0;
            for (int i = 0; i < core_pkg::mul_latency; i++) begin
                mul_pipe[i] <= '0;
            end
        end else begin
            // alu result lands one cycle after issue
            alu_q.valid <= issue.valid && !is_mul;
            alu_q.tag   <= issue.tag;
            alu_q.value <= alu_result;

            // multiply travels with its tag through the stages
            mul_pipe[0].valid <= issue.valid && is_mul;
            mul_pipe[0].tag   <= issue.tag;
            mul_pipe[0].value <= product;
            for (int i = 1; i < core_pkg::mul_latency; i++) begin
                mul_pipe[i] <= mul_pipe[i-1];
            end

            // alu loses to a multiply and waits one cycle
            skid_q       <= alu_q;
            skid_q.valid <= alu_q.valid && mul_out.valid;
        end
    end

    assign mul_out = mul_pipe[core_pkg::mul_latency-1];

    // multiply first, then a parked alu result, then a fresh one
    always_comb begin
        if (mul_out.valid) begin
            cdb_out = mul_out;
        end else if (skid_q.valid) begin
            cdb_out = skid_q;
        end else begin
            cdb_out = alu_q;
        end
    end

endmodule

/* verilog/retire_stage.sv */
// retire stage committing the buffer head to the register file or to the four-phase store port
`timescale 1ns/100ps

module retire_stage (
    input  logic                           clock,
    input  logic                           reset,
    input  core_pkg::retire_packet_t       retire_in,
    output logic                           retire_entry,
    // store port
    output logic                           store_req,
    output core_pkg::store_req_t           store_data,
    input  logic                           store_ack,
    // register read port
    input  logic [core_pkg::reg_bits-1:0]  reg_read_addr,
    output logic [core_pkg::xlen-1:0]      reg_read_data
);

    // store handshake sequencing
    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_free,
        st_drain
    } store_state_e;

    store_state_e              state;
    logic [core_pkg::xlen-1:0] regs [core_pkg::num_regs];
    logic                      reg_commit;

    // non-store heads leave right away except while a store is pending
    assign reg_commit = retire_in.valid && !retire_in.mem_valid && (state != st_req);

    // store head is freed one cycle after its ack
    assign retire_entry = reg_commit || (state == st_free);

    assign store_req = (state == st_req);

    ////////////////////////////////////////////////////////////////////////////
    // store FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (retire_in.valid && retire_in.mem_valid) begin
                        state <= st_req;
                    end
                end
                st_req: begin
                    if (store_ack) begin
                        state <= st_free;
                    end
                end
                // the next store must see ack low first
                st_free:  state <= store_ack ? st_drain : st_idle;
                st_drain: begin
                    if (!store_ack) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // address latched as req rises, held through the handshake
    always_ff @(posedge clock) begin
        if (state == st_idle && retire_in.valid && retire_in.mem_valid) begin
            store_data.address <= retire_in.value;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // architectural register file
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < core_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_commit && retire_in.reg_valid) begin
            regs[retire_in.dest_reg] <= retire_in.value;
        end
    end

    // register 0 is hardwired
    assign reg_read_data = (reg_read_addr == '0) ? '0 : regs[reg_read_addr];

endmodule

/* verilog/ooo_backend.sv */
// top level of the back end, wiring dispatch, reorder buffer, execution and retire together
`timescale 1ns/100ps

module ooo_backend (
    input  logic                          clock,
    input  logic                          reset,
    // instruction port
    input  logic                          in_req,
    input  core_pkg::instr_t              in_data,
    output logic                          in_ack,
    // store port
    output logic                          store_req,
    output core_pkg::store_req_t          store_data,
    input  logic                          store_ack,
    // register read port
    input  logic [core_pkg::reg_bits-1:0] reg_read_addr,
    output logic [core_pkg::xlen-1:0]     reg_read_data
);

    core_pkg::dispatch_rob_packet_t rob_alloc;
    core_pkg::rob_dispatch_packet_t rob_status;
    core_pkg::issue_packet_t        issue;
    core_pkg::cdb_packet_t          cdb;
    core_pkg::retire_packet_t       retire_head;
    logic                           retire_entry;

    dispatch_stage u_dispatch (
        .clock      (clock),
        .reset      (reset),
        .in_req     (in_req),
        .in_data    (in_data),
        .in_ack     (in_ack),
        .rob_alloc  (rob_alloc),
        .rob_status (rob_status),
        .issue      (issue)
    );

    reorder_buffer u_rob (
        .clock        (clock),
        .reset        (reset),
        .dispatch_in  (rob_alloc),
        .dispatch_out (rob_status),
        .cdb_in       (cdb),
        .retire_entry (retire_entry),
        .retire_out   (retire_head)
    );

    // results come back out of order on the data bus
    exec_unit u_exec (
        .clock   (clock),
        .reset   (reset),
        .issue   (issue),
        .cdb_out (cdb)
    );

    retire_stage u_retire (
        .clock         (clock),
        .reset         (reset),
        .retire_in     (retire_head),
        .retire_entry  (retire_entry),
        .store_req     (store_req),
        .store_data    (store_data),
        .store_ack     (store_ack),
        .reg_read_addr (reg_read_addr),
        .reg_read_data (reg_read_data)
    );

endmodule

/* sim/ooo_backend_checker.sv */
// assertions bound into the back end top level, covering handshakes and reorder buffer bookkeeping
`timescale 1ns/100ps

module ooo_backend_checker (
    input logic                           clock,
    input logic                           reset,
    input logic                           in_req,
    input logic                           in_ack,
    input logic                           store_req,
    input core_pkg::store_req_t           store_data,
    input logic                           store_ack,
    input core_pkg::cdb_packet_t          cdb,
    input logic                           cdb_tag_empty,
    input core_pkg::dispatch_rob_packet_t rob_alloc,
    input logic                           tail_slot_empty
);

    // ack only answers a request
    ack_needs_req: assert property (@(posedge clock) disable iff (reset)
        $rose(in_ack) |-> $past(in_req))
        else $error("in_ack rose without in_req");

    // address held for the whole store handshake
    store_data_stable: assert property (@(posedge clock) disable iff (reset)
        (store_req && $past(store_req)) |-> $stable(store_data))
        else $error("store_data changed while store_req was high");

    // previous store fully finished
    store_req_after_ack_low: assert property (@(posedge clock) disable iff (reset)
        $rose(store_req) |-> !store_ack)
        else $error("store_req rose while store_ack was still high");

    cdb_tag_in_use: assert property (@(posedge clock) disable iff (reset)
        cdb.valid |-> !cdb_tag_empty)
        else $error("data bus result for an empty reorder buffer entry");

    // a full buffer has no free slot at its tail
    no_alloc_when_full: assert property (@(posedge clock) disable iff (reset)
        rob_alloc.valid |-> tail_slot_empty)
        else $error("allocation while the reorder buffer is full");

endmodule

bind ooo_backend ooo_backend_checker u_checker (
    .clock           (clock),
    .reset           (reset),
    .in_req          (in_req),
    .in_ack          (in_ack),
    .store_req       (store_req),
    .store_data      (store_data),
    .store_ack       (store_ack),
    .cdb             (cdb),
    .cdb_tag_empty   (u_rob.entry_state[cdb.tag] == core_pkg::rob_empty),
    .rob_alloc       (rob_alloc),
    .tail_slot_empty (u_rob.entry_state[rob_status.tail_tag] == core_pkg::rob_empty)
);

/* sim/ooo_backend_tb.sv */
// testbench for the back end; random instructions from an LFSR are checked against an in-order model
`timescale 1ns/100ps

module ooo_backend_tb;

    localparam int num_instrs = 300;
    localparam int wait_limit = 2000;
    // occasional long store ack stall to fill the reorder buffer
    localparam int long_stall = 40;

    logic                          clock;
    logic                          reset;
    logic                          in_req;
    core_pkg::instr_t              in_data;
    logic                          in_ack;
    logic                          store_req;
    core_pkg::store_req_t          store_data;
    logic                          store_ack;
    logic [core_pkg::reg_bits-1:0] reg_read_addr;
    logic [core_pkg::xlen-1:0]     reg_read_data;

    // stimulus, built once at time 0
    core_pkg::instr_t instrs     [num_instrs];
    int               rise_delay [num_instrs];
    int               fall_delay [num_instrs];
    logic [31:0]      lfsr;

    // in-order model
    logic [core_pkg::xlen-1:0] model_regs [core_pkg::num_regs];
    logic [core_pkg::xlen-1:0] store_queue [$];
    int                        store_pos [$];
    int                        accepted;
    logic                      stim_done;

    ooo_backend DUT (
        .clock         (clock),
        .reset         (reset),
        .in_req        (in_req),
        .in_data       (in_data),
        .in_ack        (in_ack),
        .store_req     (store_req),
        .store_data    (store_data),
        .store_ack     (store_ack),
        .reg_read_addr (reg_read_addr),
        .reg_read_data (reg_read_data)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////////////////////
    // random source and reporting
    ////////////////////////////////////////////////////////////////////////////

    // galois LFSR, taps 32 30 26 25
    function automatic logic next_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'hA300_0000;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], next_bit()};
        end
        return r;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR at %0t: %s is %h, expected %h",
                                $time, name, actual, expected));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] model_result(input core_pkg::instr_t ins);
        case (ins.opcode)
            core_pkg::op_add:   return ins.operand_a + ins.operand_b;
            core_pkg::op_sub:   return ins.operand_a - ins.operand_b;
            core_pkg::op_xor:   return ins.operand_a ^ ins.operand_b;
            core_pkg::op_and:   return ins.operand_a & ins.operand_b;
            // low word of the product
            core_pkg::op_mul:   return ins.operand_a * ins.operand_b;
            core_pkg::op_store: return ins.operand_a + ins.operand_b;
            default:            return '0;
        endcase
    endfunction

    // runs in acceptance order, which is program order
    task automatic model_accept(input core_pkg::instr_t ins);
        if (ins.opcode == core_pkg::op_store) begin
            store_queue.push_back(model_result(ins));
            store_pos.push_back(accepted);
        end else if (ins.opcode != core_pkg::op_nop && ins.dest_reg != '0) begin
            model_regs[ins.dest_reg] = model_result(ins);
        end
        accepted++;
        // nothing behind the oldest unacked store can have retired
        if (store_pos.size() > 0 && accepted - store_pos[0] > core_pkg::rob_sz) begin
            abort_run($sformatf("more than %0d instructions in flight at %0t",
                                core_pkg::rob_sz, $time));
        end
    endtask

    function automatic void build_stimulus();
        logic [31:0] r;
        for (int i = 0; i < num_instrs; i++) begin
            r = rand_bits(3);
            // spare encoding gives extra multiplies
            instrs[i].opcode    = (r == 7) ? core_pkg::op_mul : core_pkg::opcode_e'(r[2:0]);
            r = rand_bits(3);
            instrs[i].dest_reg  = r[core_pkg::reg_bits-1:0];
            instrs[i].operand_a = rand_bits(32);
            instrs[i].operand_b = rand_bits(32);
            rise_delay[i] = rand_bits(2);
            if (rand_bits(3) == 0) begin
                rise_delay[i] += long_stall;
            end
            fall_delay[i] = rand_bits(2);
        end
        // multiply then alu op on r5, the alu value must survive
        instrs[num_instrs-2] = '{core_pkg::op_mul, 5'd5, 32'h0001_2345, 32'h0000_0777};
        instrs[num_instrs-1] = '{core_pkg::op_add, 5'd5, 32'h1111_0000, 32'h0000_2222};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // port handshakes, all called on a rising edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic send_instr(input core_pkg::instr_t ins);
        int waited;
        in_req  <= 1'b1;
        in_data <= ins;
        waited = 0;
        do begin
            @(posedge clock);
            waited++;
            if (waited > wait_limit) begin
                abort_run("timeout waiting for in_ack to rise");
            end
        end while (!in_ack);
        model_accept(ins);
        in_req <= 1'b0;
        waited = 0;
        while (in_ack) begin
            @(posedge clock);
            waited++;
            if (waited > wait_limit) begin
                abort_run("timeout waiting for in_ack to fall");
            end
        end
    endtask

    task automatic read_reg(input int addr, output logic [31:0] data);
        reg_read_addr <= addr[core_pkg::reg_bits-1:0];
        @(posedge clock);
        data = reg_read_data;
    endtask

    // store side of the environment
    initial begin : store_responder
        int waited;
        int n;
        n = 0;
        @(posedge clock);
        while (!stim_done) begin
            @(posedge clock);
            if (store_req === 1'b1) begin
                if (store_queue.size() == 0) begin
                    abort_run("store request with no store outstanding in the model");
                end
                check_value("store_data.address", store_data.address, store_queue[0]);
                repeat (rise_delay[n % num_instrs]) @(posedge clock);
                store_ack <= 1'b1;
                // counted as retired once acked
                void'(store_queue.pop_front());
                void'(store_pos.pop_front());
                waited = 0;
                while (store_req) begin
                    @(posedge clock);
                    waited++;
                    if (waited > wait_limit) begin
                        abort_run("timeout waiting for store_req to fall");
                    end
                end
                repeat (fall_delay[n % num_instrs]) @(posedge clock);
                store_ack <= 1'b0;
                n++;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin : main_sequence
        logic [31:0] data;
        int          waited;
        reset         = 1'b1;
        in_req        = 1'b0;
        in_data       = '0;
        store_ack     = 1'b0;
        reg_read_addr = '0;
        lfsr          = 32'h5f09;
        accepted      = 0;
        stim_done     = 1'b0;
        for (int r = 0; r < core_pkg::num_regs; r++) begin
            model_regs[r] = '0;
        end
        build_stimulus();

        repeat (8) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);

        // reset state
        check_value("in_ack", in_ack, 0);
        check_value("store_req", store_req, 0);
        for (int r = 0; r < core_pkg::num_regs; r++) begin
            read_reg(r, data);
            check_value($sformatf("reg_read_data[%0d]", r), data, 0);
        end

        for (int i = 0; i < num_instrs; i++) begin
            send_instr(instrs[i]);
        end

        // drain, every store acked
        waited = 0;
        while (store_queue.size() != 0) begin
            @(posedge clock);
            waited++;
            if (waited > wait_limit) begin
                abort_run("timeout waiting for the outstanding stores to complete");
            end
        end

        // last results may still be on their way to the register file
        for (int r = 0; r < core_pkg::num_regs; r++) begin
            waited = 0;
            read_reg(r, data);
            while (data !== model_regs[r] && waited < wait_limit) begin
                read_reg(r, data);
                waited++;
            end
            check_value($sformatf("reg_read_data[%0d]", r), data, model_regs[r]);
        end

        stim_done = 1'b1;
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* tb.f */
verilog/core_pkg.sv
verilog/dispatch_stage.sv
verilog/reorder_buffer.sv
verilog/exec_unit.sv
verilog/retire_stage.sv
verilog/ooo_backend.sv
sim/ooo_backend_checker.sv
sim/ooo_backend_tb.sv
